//--- hw/dual_issue_defines.svh
`ifndef DUAL_ISSUE_DEFINES_SVH
`define DUAL_ISSUE_DEFINES_SVH

// datapath widths
`define DI_XLEN        32
`define DI_PC_W        32
`define DI_IMM_W       16

// register file shape
`define DI_REG_COUNT   32
`define DI_REG_ADDR_W  5

// alu op encoding width
`define DI_OP_W        3

`endif

//--- hw/dual_issue_pkg.sv
`default_nettype none
`include "dual_issue_defines.svh"

package dual_issue_pkg;

    typedef logic [`DI_XLEN-1:0]       word_t;
    typedef logic [`DI_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`DI_IMM_W-1:0]      imm_t;
    typedef logic [`DI_PC_W-1:0]       pc_t;

    // register ops first, then the immediate forms
    typedef enum logic [`DI_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_ADDI,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [0:0] {
        ISSUE_PAIR,
        ISSUE_BETA
    } issue_state_t;

endpackage

`default_nettype wire

//--- hw/regfile_dual.sv
`timescale 1ns/1ps
`default_nettype none
`include "dual_issue_defines.svh"

module regfile_dual (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      we_alpha,
    input  logic                      we_beta,
    input  dual_issue_pkg::reg_addr_t waddr_alpha,
    input  dual_issue_pkg::reg_addr_t waddr_beta,
    input  dual_issue_pkg::word_t     wdata_alpha,
    input  dual_issue_pkg::word_t     wdata_beta,
    input  dual_issue_pkg::reg_addr_t raddr_rs_alpha,
    input  dual_issue_pkg::reg_addr_t raddr_rt_alpha,
    input  dual_issue_pkg::reg_addr_t raddr_rs_beta,
    input  dual_issue_pkg::reg_addr_t raddr_rt_beta,
    output dual_issue_pkg::word_t     rdata_rs_alpha,
    output dual_issue_pkg::word_t     rdata_rt_alpha,
    output dual_issue_pkg::word_t     rdata_rs_beta,
    output dual_issue_pkg::word_t     rdata_rt_beta
);
    import dual_issue_pkg::*;

    word_t regs [`DI_REG_COUNT];

    // beta is later in program order, so its write lands last
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DI_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (we_alpha && waddr_alpha != '0)
                regs[waddr_alpha] <= wdata_alpha;
            if (we_beta && waddr_beta != '0)
                regs[waddr_beta] <= wdata_beta;
        end
    end

    // write-first read, beta bypass checked before alpha
    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0)
            val = '0;
        else if (we_beta && waddr_beta == addr)
            val = wdata_beta;
        else if (we_alpha && waddr_alpha == addr)
            val = wdata_alpha;
        else
            val = regs[addr];
        return val;
    endfunction

    always_comb
    begin
        rdata_rs_alpha = read_port(raddr_rs_alpha);
        rdata_rt_alpha = read_port(raddr_rt_alpha);
        rdata_rs_beta  = read_port(raddr_rs_beta);
        rdata_rt_beta  = read_port(raddr_rt_beta);
    end

endmodule

`default_nettype wire

//--- hw/issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      beta_valid,
    input  dual_issue_pkg::alu_op_t   op_alpha,
    input  dual_issue_pkg::alu_op_t   op_beta,
    input  dual_issue_pkg::reg_addr_t rd_alpha,
    input  dual_issue_pkg::reg_addr_t rs_beta,
    input  dual_issue_pkg::reg_addr_t rt_beta,
    output logic                      in_ready,
    output logic                      issue_alpha,
    output logic                      issue_beta
);
    import dual_issue_pkg::*;

    issue_state_t state;
    issue_state_t state_next;
    logic         beta_uses_rs;
    logic         beta_uses_rt;
    logic         dependent;

    // lui reads no register, addi reads only rs
    assign beta_uses_rs = (op_beta != ALU_LUI);
    assign beta_uses_rt = (op_beta != ALU_LUI) && (op_beta != ALU_ADDI);

    assign dependent = in_valid && beta_valid && (rd_alpha != '0)
                       && ((beta_uses_rs && rs_beta == rd_alpha)
                           || (beta_uses_rt && rt_beta == rd_alpha));

    always_comb
    begin
        state_next  = state;
        issue_alpha = 1'b0;
        issue_beta  = 1'b0;
        in_ready    = 1'b1;
        case (state)
            ISSUE_PAIR:
            begin
                issue_alpha = in_valid;
                if (dependent)
                begin
                    // hold the pair, beta goes next cycle
                    in_ready   = 1'b0;
                    state_next = ISSUE_BETA;
                end
                else
                    issue_beta = in_valid && beta_valid;
            end
            ISSUE_BETA:
            begin
                issue_beta = in_valid && beta_valid;
                if (in_valid)
                    state_next = ISSUE_PAIR;
            end
            default: state_next = ISSUE_PAIR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ISSUE_PAIR;
        else
            state <= state_next;
    end

endmodule

`default_nettype wire

//--- hw/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  dual_issue_pkg::reg_addr_t rs,
    input  dual_issue_pkg::reg_addr_t rt,
    input  dual_issue_pkg::word_t     rs_data,
    input  dual_issue_pkg::word_t     rt_data,
    input  logic                      own_valid,
    input  dual_issue_pkg::reg_addr_t own_num,
    input  dual_issue_pkg::word_t     own_data,
    input  logic                      peer_valid,
    input  dual_issue_pkg::reg_addr_t peer_num,
    input  dual_issue_pkg::word_t     peer_data,
    input  logic                      peer_is_newer,
    output dual_issue_pkg::word_t     rs_fwd,
    output dual_issue_pkg::word_t     rt_fwd
);
    import dual_issue_pkg::*;

    logic rs_own_hit;
    logic rs_peer_hit;
    logic rt_own_hit;
    logic rt_peer_hit;

    // r0 never matches
    assign rs_own_hit  = own_valid && (own_num != '0) && (own_num == rs);
    assign rs_peer_hit = peer_valid && (peer_num != '0) && (peer_num == rs);
    assign rt_own_hit  = own_valid && (own_num != '0) && (own_num == rt);
    assign rt_peer_hit = peer_valid && (peer_num != '0) && (peer_num == rt);

    function automatic word_t pick(
        input logic  own_hit,
        input logic  peer_hit,
        input logic  peer_first,
        input word_t own_val,
        input word_t peer_val,
        input word_t base
    );
        word_t val;
        if (peer_hit && (peer_first || !own_hit))
            val = peer_val;
        else if (own_hit)
            val = own_val;
        else
            val = base;
        return val;
    endfunction

    assign rs_fwd = pick(rs_own_hit, rs_peer_hit, peer_is_newer, own_data, peer_data, rs_data);
    assign rt_fwd = pick(rt_own_hit, rt_peer_hit, peer_is_newer, own_data, peer_data, rt_data);

endmodule

`default_nettype wire

//--- hw/exec_lane.sv
`timescale 1ns/1ps
`default_nettype none
`include "dual_issue_defines.svh"

module exec_lane (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  dual_issue_pkg::alu_op_t   op,
    input  dual_issue_pkg::reg_addr_t rd,
    input  dual_issue_pkg::reg_addr_t rs,
    input  dual_issue_pkg::reg_addr_t rt,
    input  dual_issue_pkg::imm_t      imm,
    input  dual_issue_pkg::pc_t       pc,
    input  dual_issue_pkg::word_t     rs_data,
    input  dual_issue_pkg::word_t     rt_data,
    input  logic                      peer_wb_valid,
    input  dual_issue_pkg::reg_addr_t peer_wb_num,
    input  dual_issue_pkg::word_t     peer_wb_data,
    input  logic                      peer_is_newer,
    output logic                      wb_valid,
    output dual_issue_pkg::reg_addr_t wb_num,
    output dual_issue_pkg::word_t     wb_data,
    output dual_issue_pkg::pc_t       wb_pc
);
    import dual_issue_pkg::*;

    logic      ex_valid;
    alu_op_t   ex_op;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    imm_t      ex_imm;
    pc_t       ex_pc;
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    word_t     opa;
    word_t     rt_fwd;
    word_t     opb;
    word_t     imm_sext;
    word_t     alu_result;

    always_ff @(posedge clk)
    begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            ex_op      <= op;
            ex_rd      <= rd;
            ex_rs      <= rs;
            ex_rt      <= rt;
            ex_imm     <= imm;
            ex_pc      <= pc;
            ex_rs_data <= rs_data;
            ex_rt_data <= rt_data;
        end
    end

    // bypass from both writeback registers
    forward_unit fwd0 (
        .rs            (ex_rs),
        .rt            (ex_rt),
        .rs_data       (ex_rs_data),
        .rt_data       (ex_rt_data),
        .own_valid     (wb_valid),
        .own_num       (wb_num),
        .own_data      (wb_data),
        .peer_valid    (peer_wb_valid),
        .peer_num      (peer_wb_num),
        .peer_data     (peer_wb_data),
        .peer_is_newer (peer_is_newer),
        .rs_fwd        (opa),
        .rt_fwd        (rt_fwd)
    );

    assign imm_sext = {{(`DI_XLEN-`DI_IMM_W){ex_imm[`DI_IMM_W-1]}}, ex_imm};
    assign opb      = (ex_op == ALU_ADDI) ? imm_sext : rt_fwd;

    always_comb
    begin
        case (ex_op)
            ALU_ADD:  alu_result = opa + opb;
            ALU_SUB:  alu_result = opa - opb;
            ALU_AND:  alu_result = opa & opb;
            ALU_OR:   alu_result = opa | opb;
            ALU_XOR:  alu_result = opa ^ opb;
            ALU_SLT:  alu_result = {{(`DI_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_ADDI: alu_result = opa + opb;
            ALU_LUI:  alu_result = {ex_imm, {(`DI_XLEN-`DI_IMM_W){1'b0}}};
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ex_valid)
        begin
            wb_num  <= ex_rd;
            wb_data <= alu_result;
            wb_pc   <= ex_pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic                      beta_valid,
    input  dual_issue_pkg::alu_op_t   op_alpha,
    input  dual_issue_pkg::alu_op_t   op_beta,
    input  dual_issue_pkg::reg_addr_t rd_alpha,
    input  dual_issue_pkg::reg_addr_t rs_alpha,
    input  dual_issue_pkg::reg_addr_t rt_alpha,
    input  dual_issue_pkg::reg_addr_t rd_beta,
    input  dual_issue_pkg::reg_addr_t rs_beta,
    input  dual_issue_pkg::reg_addr_t rt_beta,
    input  dual_issue_pkg::imm_t      imm_alpha,
    input  dual_issue_pkg::imm_t      imm_beta,
    input  dual_issue_pkg::pc_t       pc_alpha,
    input  dual_issue_pkg::pc_t       pc_beta,
    output logic                      in_ready,
    output logic                      wb_valid_alpha,
    output logic                      wb_valid_beta,
    output dual_issue_pkg::reg_addr_t wb_num_alpha,
    output dual_issue_pkg::reg_addr_t wb_num_beta,
    output dual_issue_pkg::word_t     wb_data_alpha,
    output dual_issue_pkg::word_t     wb_data_beta,
    output dual_issue_pkg::pc_t       wb_pc_alpha,
    output dual_issue_pkg::pc_t       wb_pc_beta
);
    import dual_issue_pkg::*;

    logic  issue_alpha;
    logic  issue_beta;
    word_t rs_data_alpha;
    word_t rt_data_alpha;
    word_t rs_data_beta;
    word_t rt_data_beta;

    issue_unit issue0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .beta_valid  (beta_valid),
        .op_alpha    (op_alpha),
        .op_beta     (op_beta),
        .rd_alpha    (rd_alpha),
        .rs_beta     (rs_beta),
        .rt_beta     (rt_beta),
        .in_ready    (in_ready),
        .issue_alpha (issue_alpha),
        .issue_beta  (issue_beta)
    );

    // written from the writeback registers, read with the held inputs
    regfile_dual rf0 (
        .clk            (clk),
        .rst            (rst),
        .we_alpha       (wb_valid_alpha),
        .we_beta        (wb_valid_beta),
        .waddr_alpha    (wb_num_alpha),
        .waddr_beta     (wb_num_beta),
        .wdata_alpha    (wb_data_alpha),
        .wdata_beta     (wb_data_beta),
        .raddr_rs_alpha (rs_alpha),
        .raddr_rt_alpha (rt_alpha),
        .raddr_rs_beta  (rs_beta),
        .raddr_rt_beta  (rt_beta),
        .rdata_rs_alpha (rs_data_alpha),
        .rdata_rt_alpha (rt_data_alpha),
        .rdata_rs_beta  (rs_data_beta),
        .rdata_rt_beta  (rt_data_beta)
    );

    // beta's writeback is the newer one for alpha's bypass
    exec_lane lane_alpha (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue_alpha),
        .op            (op_alpha),
        .rd            (rd_alpha),
        .rs            (rs_alpha),
        .rt            (rt_alpha),
        .imm           (imm_alpha),
        .pc            (pc_alpha),
        .rs_data       (rs_data_alpha),
        .rt_data       (rt_data_alpha),
        .peer_wb_valid (wb_valid_beta),
        .peer_wb_num   (wb_num_beta),
        .peer_wb_data  (wb_data_beta),
        .peer_is_newer (1'b1),
        .wb_valid      (wb_valid_alpha),
        .wb_num        (wb_num_alpha),
        .wb_data       (wb_data_alpha),
        .wb_pc         (wb_pc_alpha)
    );

    exec_lane lane_beta (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue_beta),
        .op            (op_beta),
        .rd            (rd_beta),
        .rs            (rs_beta),
        .rt            (rt_beta),
        .imm           (imm_beta),
        .pc            (pc_beta),
        .rs_data       (rs_data_beta),
        .rt_data       (rt_data_beta),
        .peer_wb_valid (wb_valid_alpha),
        .peer_wb_num   (wb_num_alpha),
        .peer_wb_data  (wb_data_alpha),
        .peer_is_newer (1'b0),
        .wb_valid      (wb_valid_beta),
        .wb_num        (wb_num_beta),
        .wb_data       (wb_data_beta),
        .wb_pc         (wb_pc_beta)
    );

endmodule

`default_nettype wire

//--- bench/dual_issue_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core_chk (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic wb_valid_alpha,
    input logic wb_valid_beta
);

    // split stall lasts exactly one cycle
    stall_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        !in_ready |=> in_ready
    ) else $error("in_ready low on two consecutive cycles");

    // nothing leaves the pipe during reset or right after
    quiet_after_reset: assert property (
        @(posedge clk)
        ($past(rst) || $past(rst, 2)) |-> !(wb_valid_alpha || wb_valid_beta)
    ) else $error("writeback during reset or in the cycle after");

    // a lone beta writeback comes only from a split pair
    beta_alone_from_split: assert property (
        @(posedge clk) disable iff (rst)
        (wb_valid_beta && !wb_valid_alpha) |-> !$past(in_ready, 3)
    ) else $error("beta wrote back alone without a split");

    split_gives_beta_alone: assert property (
        @(posedge clk) disable iff (rst)
        !in_ready |-> ##3 (wb_valid_beta && !wb_valid_alpha)
    ) else $error("split pair did not end in a lone beta writeback");

endmodule

`default_nettype wire

//--- bench/dual_issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dual_issue_defines.svh"

module dual_issue_core_tb;
    import dual_issue_pkg::*;

    localparam int READY_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int RANDOM_PAIRS  = 500;

    typedef struct packed {
        int unsigned due;
        pc_t         pc;
        word_t       data;
        reg_addr_t   num;
    } wb_exp_t;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      beta_valid;
    alu_op_t   op_alpha;
    alu_op_t   op_beta;
    reg_addr_t rd_alpha;
    reg_addr_t rs_alpha;
    reg_addr_t rt_alpha;
    reg_addr_t rd_beta;
    reg_addr_t rs_beta;
    reg_addr_t rt_beta;
    imm_t      imm_alpha;
    imm_t      imm_beta;
    pc_t       pc_alpha;
    pc_t       pc_beta;
    logic      in_ready;
    logic      wb_valid_alpha;
    logic      wb_valid_beta;
    reg_addr_t wb_num_alpha;
    reg_addr_t wb_num_beta;
    word_t     wb_data_alpha;
    word_t     wb_data_beta;
    pc_t       wb_pc_alpha;
    pc_t       wb_pc_beta;

    word_t       model_regs [`DI_REG_COUNT];
    wb_exp_t     exp_alpha [$];
    wb_exp_t     exp_beta [$];
    string       test_name = "reset";
    int          err_count = 0;
    int unsigned edge_count = 0;
    int unsigned seed_dummy;
    pc_t         pc_next;

    dual_issue_core dut0 (.*);

    bind dual_issue_core dual_issue_core_chk chk0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        edge_count <= edge_count + 1;

    task automatic fail_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
            fail_run($sformatf("Error: %s %s expected 0x%0h actual 0x%0h",
                               test_name, what, expected, actual));
    endtask

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b,
                                      input imm_t imm);
        word_t imm_ext;
        word_t r;
        imm_ext = {{16{imm[15]}}, imm};
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_ADDI: r = a + imm_ext;
            ALU_LUI:  r = {imm, 16'h0000};
            default:  r = 'x;
        endcase
        return r;
    endfunction

    // beta reads alpha's fresh rd in the same pair
    function automatic logic pair_dependent(input alu_op_t op_b, input logic bv,
                                            input reg_addr_t rd_a, input reg_addr_t rs_b,
                                            input reg_addr_t rt_b);
        logic rs_hit;
        logic rt_hit;
        rs_hit = (op_b != ALU_LUI) && (rs_b == rd_a);
        rt_hit = (op_b != ALU_LUI) && (op_b != ALU_ADDI) && (rt_b == rd_a);
        return bv && (rd_a != '0) && (rs_hit || rt_hit);
    endfunction

    function automatic reg_addr_t rand_reg();
        reg_addr_t r;
        // small range most of the time for more hazards
        if ($urandom_range(0, 3) == 0)
            r = reg_addr_t'($urandom_range(0, 31));
        else
            r = reg_addr_t'($urandom_range(0, 7));
        return r;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_pair(input alu_op_t op_a, input reg_addr_t rd_a, input reg_addr_t rs_a,
                             input reg_addr_t rt_a, input imm_t imm_a, input logic bv,
                             input alu_op_t op_b, input reg_addr_t rd_b, input reg_addr_t rs_b,
                             input reg_addr_t rt_b, input imm_t imm_b);
        logic        dep;
        int unsigned first_seen;
        int unsigned accept_seen;
        int          waits;
        word_t       res_a;
        word_t       res_b;
        dep = pair_dependent(op_b, bv, rd_a, rs_b, rt_b);
        in_valid   = 1'b1;
        beta_valid = bv;
        op_alpha   = op_a;
        rd_alpha   = rd_a;
        rs_alpha   = rs_a;
        rt_alpha   = rt_a;
        imm_alpha  = imm_a;
        pc_alpha   = pc_next;
        op_beta    = op_b;
        rd_beta    = rd_b;
        rs_beta    = rs_b;
        rt_beta    = rt_b;
        imm_beta   = imm_b;
        pc_beta    = pc_next + 4;
        @(negedge clk);
        first_seen = edge_count;
        check_value("in_ready", !dep, in_ready);
        waits = 0;
        while (!in_ready)
        begin
            @(negedge clk);
            waits++;
            if (waits > READY_TIMEOUT)
                fail_run("timeout waiting for in_ready");
        end
        accept_seen = edge_count;
        if (dep)
            check_value("stall cycles", 1, accept_seen - first_seen);
        // program order, alpha first
        res_a = alu_ref(op_a, model_regs[rs_a], model_regs[rt_a], imm_a);
        exp_alpha.push_back('{due: first_seen + 2, pc: pc_next, data: res_a, num: rd_a});
        if (rd_a != '0)
            model_regs[rd_a] = res_a;
        if (bv)
        begin
            res_b = alu_ref(op_b, model_regs[rs_b], model_regs[rt_b], imm_b);
            exp_beta.push_back('{due: accept_seen + 2, pc: pc_next + 4, data: res_b,
                                 num: rd_b});
            if (rd_b != '0)
                model_regs[rd_b] = res_b;
        end
        @(posedge clk);
        #1;
        in_valid   = 1'b0;
        beta_valid = 1'b0;
        pc_next    = pc_next + 8;
    endtask

    task automatic watch_lane(input string lane, input logic valid, input reg_addr_t num,
                              input word_t data, input pc_t pc, ref wb_exp_t q[$]);
        wb_exp_t e;
        if (valid)
        begin
            if (q.size() == 0)
                fail_run($sformatf("unexpected %s writeback at pc 0x%0h", lane, pc));
            else
            begin
                e = q.pop_front();
                check_value({lane, " cycle"}, e.due, edge_count);
                check_value({lane, " num"}, e.num, num);
                check_value({lane, " data"}, e.data, data);
                check_value({lane, " pc"}, e.pc, pc);
            end
        end
        else if (q.size() != 0 && q[0].due <= edge_count)
            fail_run($sformatf("%s writeback for pc 0x%0h never appeared", lane, q[0].pc));
    endtask

    always @(negedge clk)
    begin
        if (!rst)
        begin
            watch_lane("alpha", wb_valid_alpha, wb_num_alpha, wb_data_alpha, wb_pc_alpha,
                       exp_alpha);
            watch_lane("beta", wb_valid_beta, wb_num_beta, wb_data_beta, wb_pc_beta,
                       exp_beta);
        end
    end

    task automatic drain();
        int cnt;
        cnt = 0;
        while (exp_alpha.size() != 0 || exp_beta.size() != 0)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > DRAIN_TIMEOUT)
                fail_run("timeout waiting for outstanding writebacks");
        end
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        beta_valid = 1'b0;
        op_alpha   = ALU_ADD;
        op_beta    = ALU_ADD;
        rd_alpha   = '0;
        rs_alpha   = '0;
        rt_alpha   = '0;
        rd_beta    = '0;
        rs_beta    = '0;
        rt_beta    = '0;
        imm_alpha  = '0;
        imm_beta   = '0;
        pc_alpha   = '0;
        pc_beta    = '0;
        pc_next    = 32'h0000_1000;
        seed_dummy = $urandom(67868);
        for (int i = 0; i < `DI_REG_COUNT; i++)
            model_regs[i] = '0;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_value("in_ready after reset", 1, in_ready);
        @(posedge clk);
        #1;
        idle(3);
        for (int i = 0; i < 7; i++)
            send_pair(alu_op_t'(i), i + 1, 0, 0, 0, 1, alu_op_t'(i), i + 9, 0, 0, 0);
        drain();

        test_name = "independent";
        send_pair(ALU_ADDI, 1, 0, 0, 'h1234, 1, ALU_LUI, 2, 0, 0, 'hbeef);
        send_pair(ALU_ADDI, 3, 0, 0, 'hff80, 1, ALU_ADDI, 4, 0, 0, 'h0042);
        send_pair(ALU_ADD, 5, 1, 2, 0, 1, ALU_SLT, 6, 3, 4, 0);
        drain();

        test_name = "dependent";
        send_pair(ALU_ADDI, 7, 1, 0, 'h0007, 1, ALU_SUB, 8, 7, 1, 0);
        send_pair(ALU_OR, 9, 2, 3, 0, 1, ALU_XOR, 10, 4, 9, 0);
        send_pair(ALU_ADDI, 11, 0, 0, 'h0005, 1, ALU_ADDI, 11, 11, 0, 'h0003);
        send_pair(ALU_LUI, 12, 0, 0, 'h0001, 1, ALU_ADDI, 13, 0, 12, 'h0001);
        drain();

        test_name = "forwarding";
        send_pair(ALU_ADD, 14, 7, 8, 0, 1, ALU_SUB, 15, 1, 2, 0);
        send_pair(ALU_XOR, 16, 15, 14, 0, 1, ALU_AND, 17, 14, 5, 0);
        send_pair(ALU_ADDI, 18, 0, 0, 'h0001, 1, ALU_ADDI, 18, 0, 0, 'h0002);
        send_pair(ALU_ADD, 19, 18, 0, 0, 1, ALU_OR, 20, 0, 18, 0);
        send_pair(ALU_ADDI, 21, 0, 0, 'h0011, 1, ALU_ADDI, 21, 0, 0, 'h0022);
        idle(1);
        send_pair(ALU_ADD, 22, 21, 21, 0, 0, ALU_ADD, 0, 0, 0, 0);
        idle(2);
        send_pair(ALU_SUB, 23, 21, 18, 0, 1, ALU_SLT, 24, 23, 21, 0);
        drain();

        test_name = "register zero";
        send_pair(ALU_ADDI, 0, 1, 0, 'h0055, 1, ALU_ADD, 25, 0, 1, 0);
        send_pair(ALU_OR, 26, 0, 0, 0, 1, ALU_LUI, 0, 0, 0, 'hdead);
        send_pair(ALU_ADD, 27, 0, 2, 0, 1, ALU_XOR, 28, 0, 0, 0);
        idle(1);
        send_pair(ALU_ADD, 29, 0, 0, 0, 1, ALU_SLT, 30, 0, 1, 0);
        drain();

        test_name = "random";
        for (int n = 0; n < RANDOM_PAIRS; n++)
        begin
            send_pair(alu_op_t'($urandom_range(0, 7)), rand_reg(), rand_reg(), rand_reg(),
                      imm_t'($urandom), $urandom_range(0, 7) != 0,
                      alu_op_t'($urandom_range(0, 7)), rand_reg(), rand_reg(), rand_reg(),
                      imm_t'($urandom));
            if ($urandom_range(0, 3) == 0)
                idle($urandom_range(1, 3));
        end
        drain();

        if (err_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_issue_core.f
+incdir+hw
hw/dual_issue_pkg.sv
hw/regfile_dual.sv
hw/issue_unit.sv
hw/forward_unit.sv
hw/exec_lane.sv
hw/dual_issue_core.sv
bench/dual_issue_core_chk.sv
bench/dual_issue_core_tb.sv

//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/dual_issue_pkg.sv
      - hw/regfile_dual.sv
      - hw/issue_unit.sv
      - hw/forward_unit.sv
      - hw/exec_lane.sv
      - hw/dual_issue_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/dual_issue_core_chk.sv
      - bench/dual_issue_core_tb.sv
